/* files.f */
+incdir+testbench
logic/blob_pkg.sv
logic/blob_table_if.sv
logic/blob_scan_if.sv
logic/blob_row_buffer.sv
logic/blob_labeler.sv
logic/blob_label_table.sv
logic/blob_size_filter.sv
logic/blob_counter_top.sv
testbench/tb_blob_counter.sv

/* run_sim.sh */
#!/bin/sh
# build and run the blob counter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_blob_counter -f files.f
out=$(./obj_dir/Vtb_blob_counter)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* testbench/tb_blob_model.svh */
// image table, one 16-bit pattern per row, column 0 in the msb
logic [15:0] img_tab  [NUM_TESTS][IMG_ROW];
int          exp_tab  [NUM_TESTS];
int          hold_tab [NUM_TESTS];   // cycles of result back-pressure
string       name_tab [NUM_TESTS];
int unsigned lcg_state = 27;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

// flood fill with 4-connectivity, then the one-eighth size rule
function automatic int model_count(input int t);
    int lab   [IMG_ROW][IMG_COL];
    int area  [IMG_ROW*IMG_COL+1];
    int stack [IMG_ROW*IMG_COL];
    int n, sp, p, pr, pc, nr, nc, max_a, cnt;
    n = 0;
    max_a = 0;
    cnt = 0;
    for (int r = 0; r < IMG_ROW; r++) begin
        for (int c = 0; c < IMG_COL; c++) begin
            lab[r][c] = 0;
        end
    end
    for (int r = 0; r < IMG_ROW; r++) begin
        for (int c = 0; c < IMG_COL; c++) begin
            if (img_tab[t][r][IMG_COL-1-c] && lab[r][c] == 0) begin
                n++;
                area[n] = 0;
                lab[r][c] = n;
                stack[0] = r * IMG_COL + c;
                sp = 1;
                while (sp > 0) begin
                    sp--;
                    p = stack[sp];
                    pr = p / IMG_COL;
                    pc = p % IMG_COL;
                    area[n]++;
                    for (int k = 0; k < 4; k++) begin
                        nr = pr + ((k == 0) ? -1 : (k == 1) ? 1 : 0);
                        nc = pc + ((k == 2) ? -1 : (k == 3) ? 1 : 0);
                        if (nr >= 0 && nr < IMG_ROW && nc >= 0 && nc < IMG_COL) begin
                            if (img_tab[t][nr][IMG_COL-1-nc] && lab[nr][nc] == 0) begin
                                lab[nr][nc] = n;
                                stack[sp] = nr * IMG_COL + nc;
                                sp++;
                            end
                        end
                    end
                end
            end
        end
    end
    for (int i = 1; i <= n; i++) begin
        if (area[i] > max_a) max_a = area[i];
    end
    for (int i = 1; i <= n; i++) begin
        if (area[i] > (max_a >> 3)) cnt++;
    end
    return cnt;
endfunction

task automatic load_table();
    for (int r = 0; r < IMG_ROW; r++) begin
        img_tab[0][r] = 16'h0000;
        img_tab[1][r] = 16'hFFFF;
        img_tab[3][r] = (r < 10) ? 16'h8001 : (r == 10) ? 16'hFFFF : 16'h0000;  // U
        img_tab[4][r] = (r < 10) ? 16'hAAAA : (r == 10) ? 16'hFFFF : 16'h0000;  // comb
        img_tab[5][r] = 16'h0003 << r;  // staircase down to the left
    end
    // corner blobs and one in the middle, all area 4
    img_tab[2] = '{16'hC003, 16'hC003, 16'h0000, 16'h0000, 16'h0000, 16'h0180,
                   16'h0180, 16'h0000, 16'h0000, 16'h0000, 16'hC003, 16'hC003};
    // 64 pixel block, specks of 1, 7, 8 and 9 pixels
    img_tab[6] = '{16'hFF01, 16'hFF00, 16'hFF08, 16'hFF08, 16'hFF08, 16'hFF08,
                   16'hFF08, 16'hFF08, 16'h0008, 16'hF380, 16'hF380, 16'h0380};
    // sparse fill, far fewer labels than 255
    for (int t = NUM_FIXED; t < NUM_TESTS; t++) begin
        for (int r = 0; r < IMG_ROW; r++) begin
            for (int c = 0; c < IMG_COL; c++) begin
                img_tab[t][r][IMG_COL-1-c] = ((lcg_next() & 32'hFF) < 32'd96);
            end
        end
    end
    exp_tab  = '{0, 1, 5, 1, 1, 1, 2, -1, -1, -1};
    hold_tab = '{0, 0, 0, 0, 0, 0, 40, 0, 0, 0};
    name_tab = '{"empty", "full", "edge_blobs", "u_shape", "comb", "staircase",
                 "specks", "random_a", "random_b", "random_c"};
    for (int t = NUM_FIXED; t < NUM_TESTS; t++) begin
        exp_tab[t] = model_count(t);
    end
endtask

/* testbench/tb_blob_counter.sv */
`timescale 1ns/1ps

module tb_blob_counter;

    localparam int IMG_COL     = 16;
    localparam int IMG_ROW     = 12;
    localparam int NUM_TESTS   = 10;
    localparam int NUM_FIXED   = 7;
    localparam int PIX_TIMEOUT = 2000;
    localparam int RES_TIMEOUT = 5000;

    logic       i_clk;
    logic       i_rst;
    logic       i_pixel_valid;
    logic       i_pixel;
    logic       o_pixel_ready;
    logic       o_count_valid;
    logic [7:0] o_count;
    logic       i_count_ready;

    int   errors;
    int   passed;
    int   stall_cycles;
    logic stuck;  // a wait ran out, stop testing

    `include "tb_blob_model.svh"

    blob_counter_top #(
        .IMG_COL (IMG_COL),
        .IMG_ROW (IMG_ROW)
    ) u_blob_counter_top (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_pixel_valid (i_pixel_valid),
        .i_pixel       (i_pixel),
        .o_pixel_ready (o_pixel_ready),
        .o_count_valid (o_count_valid),
        .o_count       (o_count),
        .i_count_ready (i_count_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // raster order, ready sampled at the falling edge
    task automatic send_frame(input int t);
        int waits;
        for (int r = 0; r < IMG_ROW; r++) begin
            for (int c = 0; c < IMG_COL; c++) begin
                i_pixel_valid = 1'b1;
                i_pixel       = img_tab[t][r][IMG_COL-1-c];
                waits = 0;
                @(negedge i_clk);
                while (!o_pixel_ready && waits < PIX_TIMEOUT) begin
                    @(negedge i_clk);
                    waits++;
                end
                stall_cycles += waits;
                if (!o_pixel_ready) begin
                    $display("test %0d: pixel at row %0d col %0d was never accepted", t, r, c);
                    errors++;
                    stuck = 1'b1;
                    i_pixel_valid = 1'b0;
                    return;
                end
                @(posedge i_clk);
                #1;
            end
        end
        i_pixel_valid = 1'b0;
    endtask

    task automatic take_result(input int t, output logic [7:0] got);
        int waits;
        waits = 0;
        got = '0;
        @(negedge i_clk);
        while (!o_count_valid && waits < RES_TIMEOUT) begin
            @(negedge i_clk);
            waits++;
        end
        if (!o_count_valid) begin
            $display("test %0d: no result arrived after the last pixel", t);
            errors++;
            stuck = 1'b1;
            return;
        end
        got = o_count;
        if (got != 8'(exp_tab[t])) begin
            $display("FAILED o_count expected %h got %h", 8'(exp_tab[t]), got);
            errors++;
        end
        // result must sit still while nobody takes it
        for (int i = 0; i < hold_tab[t]; i++) begin
            @(negedge i_clk);
            if (!o_count_valid || o_pixel_ready) begin
                $display("test %0d: handshake state changed under back-pressure", t);
                errors++;
            end
            if (o_count !== got) begin
                $display("FAILED o_count held %h changed to %h", got, o_count);
                errors++;
            end
        end
        @(posedge i_clk);
        #1 i_count_ready = 1'b1;
        @(posedge i_clk);
        #1 i_count_ready = 1'b0;
        @(negedge i_clk);
        if (o_count_valid) begin
            $display("test %0d: o_count_valid still high after the handshake", t);
            errors++;
        end
        @(posedge i_clk);
        #1;
    endtask

    initial begin
        int         err_before;
        logic [7:0] got;
        i_rst         = 1'b1;
        i_pixel_valid = 1'b0;
        i_pixel       = 1'b0;
        i_count_ready = 1'b0;
        errors        = 0;
        passed        = 0;
        stall_cycles  = 0;
        stuck         = 1'b0;
        load_table();
        for (int t = 0; t < NUM_FIXED; t++) begin
            if (model_count(t) != exp_tab[t]) begin
                $display("test %0d: flood fill model disagrees with the table count", t);
                errors++;
            end
        end
        repeat (16) @(posedge i_clk);
        #1 i_rst = 1'b0;
        @(negedge i_clk);
        if (!o_pixel_ready || o_count_valid) begin
            $display("handshake outputs wrong after reset");
            errors++;
        end
        @(posedge i_clk);
        #1;
        for (int t = 0; t < NUM_TESTS && !stuck; t++) begin
            err_before   = errors;
            stall_cycles = 0;
            got          = '0;
            send_frame(t);
            if (!stuck) take_result(t, got);
            if (errors == err_before) passed++;
            $display("test %0d %s: expected %0d got %0d, %0d stall cycles, %s", t, name_tab[t],
                     exp_tab[t], got, stall_cycles, (errors == err_before) ? "ok" : "bad");
        end
        $display("%0d of %0d tests passed, %0d errors", passed, NUM_TESTS, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* logic/blob_counter_top.sv */
`timescale 1ns/1ps

module blob_counter_top #(
    parameter int IMG_COL = 16,
    parameter int IMG_ROW = 12
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_pixel_valid,
    input  logic       i_pixel,
    output logic       o_pixel_ready,
    output logic       o_count_valid,
    output logic [7:0] o_count,
    input  logic       i_count_ready
);
    import blob_pkg::*;

    // labeler to row buffer
    logic   row_shift;
    logic   row_clear;
    label_t row_label;
    label_t row_up;
    label_t row_left;

    blob_table_if u_table_if ();
    blob_scan_if  u_scan_if ();

    blob_row_buffer #(
        .IMG_COL (IMG_COL)
    ) u_blob_row_buffer (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_shift (row_shift),
        .i_label (row_label),
        .i_clear (row_clear),
        .o_up    (row_up),
        .o_left  (row_left)
    );

    blob_labeler #(
        .IMG_COL (IMG_COL),
        .IMG_ROW (IMG_ROW)
    ) u_blob_labeler (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_pixel_valid (i_pixel_valid),
        .i_pixel       (i_pixel),
        .o_pixel_ready (o_pixel_ready),
        .table_if      (u_table_if.labeler_mp),
        .o_shift       (row_shift),
        .o_label       (row_label),
        .o_clear       (row_clear),
        .i_up          (row_up),
        .i_left        (row_left)
    );

    blob_label_table u_blob_label_table (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .table_if (u_table_if.table_mp),
        .scan_if  (u_scan_if.table_mp)
    );

    blob_size_filter u_blob_size_filter (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .scan_if       (u_scan_if.filter_mp),
        .o_count_valid (o_count_valid),
        .o_count       (o_count),
        .i_count_ready (i_count_ready)
    );

endmodule

/* logic/blob_size_filter.sv */
`timescale 1ns/1ps

module blob_size_filter (
    input  logic            i_clk,
    input  logic            i_rst,
    blob_scan_if.filter_mp  scan_if,
    output logic            o_count_valid,
    output logic [7:0]      o_count,
    input  logic            i_count_ready
);
    import blob_pkg::*;

    filter_state_e state_q;
    label_t        addr_q;
    area_t         max_q;
    area_t         thresh;
    logic [7:0]    count_q;
    logic          release_q;

    assign thresh = max_q >> 3;  // one eighth of the largest blob

    assign scan_if.start       = (state_q == F_IDLE) && scan_if.frame_done;
    assign scan_if.addr        = addr_q;
    assign scan_if.release_req = release_q;

    assign o_count_valid = (state_q == F_OUT);
    assign o_count       = count_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q   <= F_IDLE;
            addr_q    <= '0;
            max_q     <= '0;
            count_q   <= '0;
            release_q <= 1'b0;
        end else begin
            release_q <= 1'b0;
            case (state_q)
                F_IDLE: begin
                    if (scan_if.start) begin
                        addr_q  <= '0;
                        max_q   <= '0;
                        state_q <= F_MAX;
                    end
                end
                F_MAX: begin
                    if (scan_if.is_root && scan_if.area > max_q) begin
                        max_q <= scan_if.area;
                    end
                    addr_q <= addr_q + 1'b1;
                    if (addr_q == '1) begin
                        count_q <= '0;
                        state_q <= F_COUNT;
                    end
                end
                F_COUNT: begin
                    if (scan_if.is_root && scan_if.area > thresh) begin
                        count_q <= count_q + 1'b1;
                    end
                    addr_q <= addr_q + 1'b1;
                    if (addr_q == '1) begin
                        state_q <= F_OUT;
                    end
                end
                default: begin  // F_OUT
                    if (i_count_ready) begin
                        release_q <= 1'b1;  // lets the table clear
                        state_q   <= F_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* logic/blob_label_table.sv */
`timescale 1ns/1ps

module blob_label_table (
    input logic            i_clk,
    input logic            i_rst,
    blob_table_if.table_mp table_if,
    blob_scan_if.table_mp  scan_if
);
    import blob_pkg::*;

    label_t       parent_q [NUM_LABELS];
    area_t        area_q   [NUM_LABELS];
    table_state_e state_q;
    label_t       next_q;
    label_t       ra_q;          // root walk of label_a
    label_t       rb_q;          // root walk of label_b
    label_t       merge_idx_q;
    logic         scan_taken_q;
    logic         link_now;

    // rb_q reached its root, union completes this cycle
    assign link_now = (state_q == T_FIND_B) && (parent_q[rb_q] == rb_q);

    always_comb begin
        case (state_q)
            T_PROC:  table_if.op_ready = !(table_if.op_valid && table_if.op == OP_UNION);
            T_FIND_B: table_if.op_ready = link_now;
            default: table_if.op_ready = 1'b0;
        endcase
    end

    assign table_if.next_label = next_q;

    assign scan_if.frame_done = (state_q == T_HOLD) && !scan_taken_q;
    assign scan_if.area       = area_q[scan_if.addr];
    assign scan_if.is_root    = (scan_if.addr != '0) && (parent_q[scan_if.addr] == scan_if.addr);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q      <= T_PROC;
            next_q       <= label_t'(1);
            ra_q         <= '0;
            rb_q         <= '0;
            merge_idx_q  <= '0;
            scan_taken_q <= 1'b0;
            for (int i = 0; i < NUM_LABELS; i++) begin
                parent_q[i] <= '0;
                area_q[i]   <= '0;
            end
        end else begin
            case (state_q)
                T_PROC: begin
                    if (table_if.op_valid) begin
                        case (table_if.op)
                            OP_ADD: begin
                                area_q[table_if.label_a] <= area_q[table_if.label_a] + area_t'(1);
                            end
                            OP_NEW: begin
                                parent_q[next_q] <= next_q;  // own root
                                area_q[next_q]   <= area_t'(1);
                                next_q           <= next_q + 1'b1;
                            end
                            OP_UNION: begin
                                ra_q    <= table_if.label_a;
                                state_q <= T_FIND_A;
                            end
                            default: begin  // OP_END
                                merge_idx_q <= '1;
                                state_q     <= T_MERGE;
                            end
                        endcase
                    end
                end
                T_FIND_A: begin
                    if (parent_q[ra_q] == ra_q) begin
                        rb_q    <= table_if.label_b;
                        state_q <= T_FIND_B;
                    end else begin
                        ra_q <= parent_q[ra_q];
                    end
                end
                T_FIND_B: begin
                    if (link_now) begin
                        area_q[table_if.label_a] <= area_q[table_if.label_a] + area_t'(1);
                        // smaller root wins, so parents stay below children
                        if (ra_q < rb_q) begin
                            parent_q[rb_q] <= ra_q;
                        end else if (rb_q < ra_q) begin
                            parent_q[ra_q] <= rb_q;
                        end
                        state_q <= T_PROC;
                    end else begin
                        rb_q <= parent_q[rb_q];
                    end
                end
                T_MERGE: begin
                    // descending, so areas ripple down to the roots
                    if (parent_q[merge_idx_q] != merge_idx_q) begin
                        area_q[parent_q[merge_idx_q]] <= area_q[parent_q[merge_idx_q]]
                                                         + area_q[merge_idx_q];
                        area_q[merge_idx_q] <= '0;
                    end
                    merge_idx_q <= merge_idx_q - 1'b1;
                    if (merge_idx_q == label_t'(1)) begin
                        state_q <= T_HOLD;
                    end
                end
                T_HOLD: begin
                    if (scan_if.start) begin
                        scan_taken_q <= 1'b1;
                    end
                    if (scan_if.release_req) begin
                        state_q <= T_CLEAR;
                    end
                end
                default: begin  // T_CLEAR
                    for (int i = 0; i < NUM_LABELS; i++) begin
                        parent_q[i] <= '0;
                        area_q[i]   <= '0;
                    end
                    next_q       <= label_t'(1);
                    scan_taken_q <= 1'b0;
                    state_q      <= T_PROC;
                end
            endcase
        end
    end

endmodule

/* logic/blob_labeler.sv */
`timescale 1ns/1ps

module blob_labeler #(
    parameter int IMG_COL = 16,
    parameter int IMG_ROW = 12
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_pixel_valid,
    input  logic             i_pixel,
    output logic             o_pixel_ready,
    blob_table_if.labeler_mp table_if,
    output logic             o_shift,
    output blob_pkg::label_t o_label,
    output logic             o_clear,
    input  blob_pkg::label_t i_up,
    input  blob_pkg::label_t i_left
);
    import blob_pkg::*;

    localparam int COL_W = (IMG_COL > 1) ? $clog2(IMG_COL) : 1;
    localparam int ROW_W = (IMG_ROW > 1) ? $clog2(IMG_ROW) : 1;

    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             end_pend_q;  // OP_END still to be sent
    logic             accept;
    logic             last_pixel;
    label_t           left;

    // no left neighbor at column 0
    assign left = (col_q == '0) ? '0 : i_left;

    assign last_pixel = (col_q == COL_W'(IMG_COL - 1)) && (row_q == ROW_W'(IMG_ROW - 1));

    assign o_pixel_ready = table_if.op_ready && !end_pend_q;
    assign accept        = i_pixel_valid && o_pixel_ready;
    assign o_shift       = accept;
    assign o_clear       = end_pend_q && table_if.op_ready;  // OP_END taken

    // neighbor decision
    always_comb begin
        table_if.op_valid = 1'b0;
        table_if.op       = OP_ADD;
        table_if.label_a  = '0;
        table_if.label_b  = '0;
        o_label           = '0;
        if (end_pend_q) begin
            table_if.op_valid = 1'b1;
            table_if.op       = OP_END;
        end else if (i_pixel_valid && i_pixel) begin
            table_if.op_valid = 1'b1;
            if (left == '0 && i_up == '0) begin
                table_if.op      = OP_NEW;
                table_if.label_a = table_if.next_label;
                o_label          = table_if.next_label;
            end else if (left == '0) begin
                table_if.label_a = i_up;
                o_label          = i_up;
            end else if (i_up == '0 || i_up == left) begin
                table_if.label_a = left;
                o_label          = left;
            end else begin
                // two labels meet, pixel keeps the left one
                table_if.op      = OP_UNION;
                table_if.label_a = left;
                table_if.label_b = i_up;
                o_label          = left;
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            col_q      <= '0;
            row_q      <= '0;
            end_pend_q <= 1'b0;
        end else begin
            if (accept) begin
                if (col_q == COL_W'(IMG_COL - 1)) begin
                    col_q <= '0;
                    row_q <= last_pixel ? '0 : row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
            if (accept && last_pixel) begin
                end_pend_q <= 1'b1;
            end else if (o_clear) begin
                end_pend_q <= 1'b0;
            end
        end
    end

endmodule

/* logic/blob_row_buffer.sv */
`timescale 1ns/1ps

module blob_row_buffer #(
    parameter int IMG_COL = 16
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_shift,
    input  blob_pkg::label_t i_label,
    input  logic             i_clear,
    output blob_pkg::label_t o_up,
    output blob_pkg::label_t o_left
);
    import blob_pkg::*;

    // row_q[0] is the newest label, row_q[IMG_COL-1] the one a row back
    label_t row_q [IMG_COL];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 0; i < IMG_COL; i++) begin
                row_q[i] <= '0;
            end
        end else if (i_clear) begin
            // next frame starts with background above
            for (int i = 0; i < IMG_COL; i++) begin
                row_q[i] <= '0;
            end
        end else if (i_shift) begin
            row_q[0] <= i_label;
            for (int i = 1; i < IMG_COL; i++) begin
                row_q[i] <= row_q[i-1];
            end
        end
    end

    assign o_left = row_q[0];
    assign o_up   = row_q[IMG_COL-1];

endmodule

/* logic/blob_scan_if.sv */
`timescale 1ns/1ps

interface blob_scan_if;
    import blob_pkg::*;

    logic   frame_done;   // table has merged, results readable
    logic   start;        // filter takes the frame
    label_t addr;
    area_t  area;
    logic   is_root;
    logic   release_req;  // result taken, table may clear

    modport filter_mp (
        input  frame_done,
        output start,
        output addr,
        input  area,
        input  is_root,
        output release_req
    );

    modport table_mp (
        output frame_done,
        input  start,
        input  addr,
        output area,
        output is_root,
        input  release_req
    );

endinterface

/* logic/blob_table_if.sv */
`timescale 1ns/1ps

interface blob_table_if;
    import blob_pkg::*;

    logic      op_valid;
    table_op_e op;
    label_t    label_a;
    label_t    label_b;
    logic      op_ready;
    label_t    next_label;  // what OP_NEW would hand out now

    modport labeler_mp (
        output op_valid,
        output op,
        output label_a,
        output label_b,
        input  op_ready,
        input  next_label
    );

    modport table_mp (
        input  op_valid,
        input  op,
        input  label_a,
        input  label_b,
        output op_ready,
        output next_label
    );

endinterface

/* logic/blob_pkg.sv */
package blob_pkg;

    // label and area widths
    localparam int LABEL_W = 8;   // 256 labels, 0 is background
    localparam int AREA_W  = 16;

    localparam int NUM_LABELS = 1 << LABEL_W;

    typedef logic [LABEL_W-1:0] label_t;
    typedef logic [AREA_W-1:0]  area_t;

    // operations from labeler to label table
    typedef enum logic [1:0] {
        OP_ADD,     // one more pixel for label_a
        OP_NEW,     // fresh label, area one
        OP_UNION,   // pixel for label_a, join sets a and b
        OP_END      // frame done
    } table_op_e;

    typedef enum logic [2:0] {
        T_PROC,
        T_FIND_A,
        T_FIND_B,
        T_MERGE,
        T_HOLD,
        T_CLEAR
    } table_state_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_MAX,
        F_COUNT,
        F_OUT
    } filter_state_e;

endpackage
